/* logic/rv_pkg.sv */
// Shared datapath types, ALU operation codes and RV32I field constants for the pipeline
package rv_pkg;

    typedef logic [31:0] xlen_t;      // Operands, results, immediates
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int SHAMT_W = 5;       // Shift amount field width

    // ALU operations. PASS_B forwards operand B for LUI
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // Accepted major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 codes shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;  // Also SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;  // Also SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct7 codes
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB, SRA, SRAI

    // Map funct3 plus the alternate bit onto an ALU operation
    function automatic alu_op_e f3_to_op(logic [2:0] f3, logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SRL:  op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

endpackage

/* logic/stage_if.sv */
// Stage interfaces: ex_if carries issued operations, wb_if carries results back for forwarding
`timescale 1ns/10ps

interface ex_if;
    logic               valid;      // Qualifies the fields this cycle
    rv_pkg::alu_op_e    alu_op;
    rv_pkg::xlen_t      operand_a;
    rv_pkg::xlen_t      operand_b;
    rv_pkg::reg_addr_t  rd;

    modport src (
        output valid, alu_op, operand_a, operand_b, rd
    );

    modport dst (
        input valid, alu_op, operand_a, operand_b, rd
    );
endinterface

interface wb_if;
    // Combinational result of the op now in ID/EX
    logic               ex_valid;
    rv_pkg::reg_addr_t  ex_rd;
    rv_pkg::xlen_t      ex_result;
    // Registered result, written to the register file this cycle
    logic               wb_valid;
    rv_pkg::reg_addr_t  wb_rd;
    rv_pkg::xlen_t      wb_data;

    modport src (
        output ex_valid, ex_rd, ex_result, wb_valid, wb_rd, wb_data
    );

    modport dst (
        input ex_valid, ex_rd, ex_result, wb_valid, wb_rd, wb_data
    );
endinterface

/* logic/rv_regfile.sv */
// 32 x 32-bit integer register file, two combinational read ports and one write port
`timescale 1ns/10ps

module rv_regfile (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::reg_addr_t wr_addr,
    input  logic              wr_en,
    input  rv_pkg::xlen_t     wr_data,
    output rv_pkg::xlen_t     rs1_data,
    output rv_pkg::xlen_t     rs2_data
);

    rv_pkg::xlen_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;  // x0 never written
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // Write enable comes from the execute stage and must always be resolved
    a_wr_en_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(wr_en))
        else $error("regfile write enable is X");

endmodule

/* logic/rv_decode.sv */
// Decode stage: classifies the instruction, builds the immediate, reads and forwards operands
`timescale 1ns/10ps

module rv_decode (
    input  logic           clk,
    input  logic           rst,
    input  logic           instr_valid,
    input  rv_pkg::instr_t instr,
    wb_if.dst              wb,
    ex_if.src              issue
);

    logic [6:0]        opcode;
    logic [2:0]        f3;
    logic [6:0]        f7;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;

    logic              legal;
    logic              use_imm;   // Operand B from immediate
    logic              is_lui;
    rv_pkg::alu_op_e   alu_op;
    rv_pkg::xlen_t     imm;

    rv_pkg::xlen_t     rf_rs1;
    rv_pkg::xlen_t     rf_rs2;
    rv_pkg::xlen_t     rs1_val;
    rv_pkg::xlen_t     rs2_val;

    assign opcode = instr[6:0];
    assign f3     = instr[14:12];
    assign f7     = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    always_comb begin
        legal   = 1'b0;
        use_imm = 1'b0;
        is_lui  = 1'b0;
        alu_op  = rv_pkg::ALU_ADD;
        case (opcode)
            rv_pkg::OPC_OP: begin
                alu_op = rv_pkg::f3_to_op(f3, f7 == rv_pkg::F7_ALT);
                legal  = (f7 == rv_pkg::F7_BASE) ||
                         ((f7 == rv_pkg::F7_ALT) &&
                          ((f3 == rv_pkg::F3_ADD) || (f3 == rv_pkg::F3_SRL)));
            end
            rv_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                // Bit 30 only selects SRAI; for ADDI it is immediate data
                alu_op  = rv_pkg::f3_to_op(f3, (f3 == rv_pkg::F3_SRL) &&
                                               (f7 == rv_pkg::F7_ALT));
                case (f3)
                    rv_pkg::F3_SLL: legal = (f7 == rv_pkg::F7_BASE);
                    rv_pkg::F3_SRL: legal = (f7 == rv_pkg::F7_BASE) || (f7 == rv_pkg::F7_ALT);
                    default:        legal = 1'b1;
                endcase
            end
            rv_pkg::OPC_LUI: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                is_lui  = 1'b1;
                alu_op  = rv_pkg::ALU_PASS_B;
            end
            default: legal = 1'b0;  // Branches, loads, stores, jumps, AUIPC
        endcase
    end

    // U-type for LUI, sign-extended I-type otherwise
    assign imm = is_lui ? {instr[31:12], 12'b0} : {{20{instr[31]}}, instr[31:20]};

    rv_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .wr_addr  (wb.wb_rd),
        .wr_en    (wb.wb_valid),
        .wr_data  (wb.wb_data),
        .rs1_data (rf_rs1),
        .rs2_data (rf_rs2)
    );

    // Youngest producer wins; x0 always reads zero
    function automatic rv_pkg::xlen_t fwd(rv_pkg::reg_addr_t src, rv_pkg::xlen_t rf_val,
                                          logic ex_v, rv_pkg::reg_addr_t ex_rd,
                                          rv_pkg::xlen_t ex_res, logic wb_v,
                                          rv_pkg::reg_addr_t wb_rd, rv_pkg::xlen_t wb_dat);
        if (src == '0) begin
            return '0;
        end else if (ex_v && (ex_rd == src)) begin
            return ex_res;
        end else if (wb_v && (wb_rd == src)) begin
            return wb_dat;
        end
        return rf_val;
    endfunction

    assign rs1_val = fwd(rs1, rf_rs1, wb.ex_valid, wb.ex_rd, wb.ex_result,
                         wb.wb_valid, wb.wb_rd, wb.wb_data);
    assign rs2_val = fwd(rs2, rf_rs2, wb.ex_valid, wb.ex_rd, wb.ex_result,
                         wb.wb_valid, wb.wb_rd, wb.wb_data);

    assign issue.valid     = instr_valid && legal;
    assign issue.alu_op    = alu_op;
    assign issue.operand_a = is_lui ? '0 : rs1_val;
    assign issue.operand_b = use_imm ? imm : rs2_val;
    assign issue.rd        = instr[11:7];

    // Forwarded operands must be resolved when issued
    a_issue_known: assert property (@(posedge clk) disable iff (rst)
        issue.valid |-> !$isunknown({issue.alu_op, issue.operand_a,
                                     issue.operand_b, issue.rd}))
        else $error("issued operation has unknown fields");

endmodule

/* logic/rv_id_ex.sv */
// ID/EX pipeline register, holds one issued operation between decode and execute
`timescale 1ns/10ps

module rv_id_ex (
    input  logic clk,
    input  logic rst,
    ex_if.dst    in,
    ex_if.src    out
);

    logic              valid_q;
    rv_pkg::alu_op_e   alu_op_q;
    rv_pkg::xlen_t     operand_a_q;
    rv_pkg::xlen_t     operand_b_q;
    rv_pkg::reg_addr_t rd_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in.valid;  // Gaps become bubbles
        end
    end

    always_ff @(posedge clk) begin
        alu_op_q    <= in.alu_op;
        operand_a_q <= in.operand_a;
        operand_b_q <= in.operand_b;
        rd_q        <= in.rd;
    end

    assign out.valid     = valid_q;
    assign out.alu_op    = alu_op_q;
    assign out.operand_a = operand_a_q;
    assign out.operand_b = operand_b_q;
    assign out.rd        = rd_q;

endmodule

/* logic/rv_execute.sv */
// Execute stage: ALU plus the writeback register that drives the result strobe
`timescale 1ns/10ps

module rv_execute (
    input  logic clk,
    input  logic rst,
    ex_if.dst    op,
    wb_if.src    wb
);

    rv_pkg::xlen_t              result;
    logic [rv_pkg::SHAMT_W-1:0] shamt;

    logic                       wb_valid_q;
    rv_pkg::reg_addr_t          wb_rd_q;
    rv_pkg::xlen_t              wb_data_q;

    assign shamt = op.operand_b[rv_pkg::SHAMT_W-1:0];  // Upper bits ignored

    always_comb begin
        case (op.alu_op)
            rv_pkg::ALU_ADD:    result = op.operand_a + op.operand_b;
            rv_pkg::ALU_SUB:    result = op.operand_a - op.operand_b;
            rv_pkg::ALU_SLL:    result = op.operand_a << shamt;
            rv_pkg::ALU_SLT:    result = {31'b0, $signed(op.operand_a) < $signed(op.operand_b)};
            rv_pkg::ALU_SLTU:   result = {31'b0, op.operand_a < op.operand_b};
            rv_pkg::ALU_XOR:    result = op.operand_a ^ op.operand_b;
            rv_pkg::ALU_SRL:    result = op.operand_a >> shamt;
            rv_pkg::ALU_SRA:    result = rv_pkg::xlen_t'($signed(op.operand_a) >>> shamt);
            rv_pkg::ALU_OR:     result = op.operand_a | op.operand_b;
            rv_pkg::ALU_AND:    result = op.operand_a & op.operand_b;
            rv_pkg::ALU_PASS_B: result = op.operand_b;  // LUI
            default:            result = '0;
        endcase
    end

    // Distance-one forwarding path back to decode
    assign wb.ex_valid  = op.valid;
    assign wb.ex_rd     = op.rd;
    assign wb.ex_result = result;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= op.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_q   <= op.rd;
        wb_data_q <= result;
    end

    assign wb.wb_valid = wb_valid_q;
    assign wb.wb_rd    = wb_rd_q;
    assign wb.wb_data  = wb_data_q;

    // Decode picks the op, ID/EX carries it; it must land on a real encoding
    a_op_defined: assert property (@(posedge clk) disable iff (rst)
        op.valid |-> (!$isunknown(op.alu_op) && (op.alu_op <= rv_pkg::ALU_PASS_B)))
        else $error("undefined ALU operation in execute");

endmodule

/* logic/rv_core.sv */
// Top level of the two-stage integer pipeline, plain strobe ports in and out
`timescale 1ns/10ps

module rv_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  rv_pkg::instr_t    instr,
    output logic              wb_valid,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::xlen_t     wb_data
);

    ex_if u_issue_if ();  // Decode to ID/EX
    ex_if u_exec_if ();   // ID/EX to execute
    wb_if u_wb_if ();     // Results and forwarding

    rv_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (u_wb_if.dst),
        .issue       (u_issue_if.src)
    );

    rv_id_ex u_id_ex (
        .clk (clk),
        .rst (rst),
        .in  (u_issue_if.dst),
        .out (u_exec_if.src)
    );

    rv_execute u_execute (
        .clk (clk),
        .rst (rst),
        .op  (u_exec_if.dst),
        .wb  (u_wb_if.src)
    );

    assign wb_valid = u_wb_if.wb_valid;
    assign wb_rd    = u_wb_if.wb_rd;
    assign wb_data  = u_wb_if.wb_data;

endmodule

/* testbench/rv_core_tb.sv */
// Testbench for rv_core: runs a directed table, then a random stream against a shadow model
`timescale 1ns/10ps

module rv_core_tb;

    localparam int CLK_PERIOD = 100;
    localparam int N_RANDOM   = 200;

    localparam logic [6:0] OPC_OP  = 7'h33;
    localparam logic [6:0] OPC_IMM = 7'h13;
    localparam logic [6:0] OPC_LUI = 7'h37;

    localparam logic [2:0] FN_ADD  = 3'd0;
    localparam logic [2:0] FN_SLL  = 3'd1;
    localparam logic [2:0] FN_SLT  = 3'd2;
    localparam logic [2:0] FN_SLTU = 3'd3;
    localparam logic [2:0] FN_XOR  = 3'd4;
    localparam logic [2:0] FN_SR   = 3'd5;
    localparam logic [2:0] FN_OR   = 3'd6;
    localparam logic [2:0] FN_AND  = 3'd7;

    typedef struct {
        int                test;
        logic              vld;     // Low for a bubble
        rv_pkg::instr_t    instr;
        logic              legal;
        rv_pkg::reg_addr_t rd;
        rv_pkg::xlen_t     data;
    } entry_t;

    logic              clk;
    logic              rst;
    logic              instr_valid;
    rv_pkg::instr_t    instr;
    logic              wb_valid;
    rv_pkg::reg_addr_t wb_rd;
    rv_pkg::xlen_t     wb_data;

    entry_t        stim_q [$];
    entry_t        pend_q [$];      // In flight, oldest first
    rv_pkg::xlen_t shadow [32];
    int            test_errs [6];
    string         names [6] = '{"reset and latency", "alu operations", "forwarding",
                                 "x0 writes", "dropped opcodes", "random stream"};
    int            cur_test = 0;
    int            n_checks = 0;
    int            n_errors = 0;
    int            n_pass = 0;
    logic          built = 1'b0;
    logic [31:0]   rnd = 32'd6321;

    rv_core u_rv_core (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic rv_pkg::instr_t enc(logic [6:0] f7, rv_pkg::reg_addr_t rs2,
                                           rv_pkg::reg_addr_t rs1, logic [2:0] f3,
                                           rv_pkg::reg_addr_t rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Architectural result from funct3 and the funct7 alternate bit
    function automatic rv_pkg::xlen_t alu_ref(logic [2:0] f3, logic alt,
                                              rv_pkg::xlen_t a, rv_pkg::xlen_t b);
        case (f3)
            FN_ADD:  return alt ? a - b : a + b;
            FN_SLL:  return a << b[4:0];
            FN_SLT:  return {31'b0, $signed(a) < $signed(b)};
            FN_SLTU: return {31'b0, a < b};
            FN_XOR:  return a ^ b;
            FN_SR:   return alt ? rv_pkg::xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            FN_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic push_entry(int t, logic vld, rv_pkg::instr_t w, logic legal, int rd,
                              rv_pkg::xlen_t d);
        entry_t e;
        e = '{t, vld, w, legal, 5'(rd), d};
        stim_q.push_back(e);
    endtask

    task automatic rtype_op(int t, int alt, logic [2:0] f3, int rd, int rs1, int rs2,
                            rv_pkg::xlen_t d);
        push_entry(t, 1'b1, enc((alt != 0) ? 7'h20 : 7'h00, 5'(rs2), 5'(rs1), f3, 5'(rd),
                   OPC_OP), 1'b1, rd, d);
    endtask

    task automatic itype_op(int t, logic [2:0] f3, int rd, int rs1, logic [11:0] imm,
                            rv_pkg::xlen_t d);
        push_entry(t, 1'b1, enc(imm[11:5], imm[4:0], 5'(rs1), f3, 5'(rd), OPC_IMM), 1'b1,
                   rd, d);
    endtask

    task automatic dropped(int t, rv_pkg::instr_t w);
        push_entry(t, 1'b1, w, 1'b0, 0, '0);
    endtask

    // Strobe low while instr holds ADDI x31, x0, 1
    task automatic bubble_slot(int t);
        push_entry(t, 1'b0, enc(7'h00, 5'd1, 5'd0, FN_ADD, 5'd31, OPC_IMM), 1'b1, 31, 1);
    endtask

    task automatic build_table();
        bubble_slot(0);
        itype_op(0, FN_ADD, 1, 0, 12'd5, 5);
        bubble_slot(0);
        itype_op(1, FN_ADD, 2, 0, 12'hff8, 32'hfffffff8);
        itype_op(1, FN_ADD, 3, 0, 12'd3, 3);
        push_entry(1, 1'b1, {20'h80000, 5'd4, OPC_LUI}, 1'b1, 4, 32'h80000000);
        rtype_op(1, 0, FN_ADD, 5, 2, 3, 32'hfffffffb);
        rtype_op(1, 1, FN_ADD, 6, 3, 2, 32'h0000000b);
        rtype_op(1, 0, FN_SLL, 7, 1, 3, 32'h28);
        rtype_op(1, 0, FN_SLT, 8, 2, 3, 1);
        rtype_op(1, 0, FN_SLTU, 9, 2, 3, 0);          // Same operands, unsigned
        rtype_op(1, 0, FN_XOR, 10, 2, 3, 32'hfffffffb);
        rtype_op(1, 1, FN_SR, 12, 4, 3, 32'hf0000000);
        rtype_op(1, 0, FN_OR, 13, 1, 3, 7);
        rtype_op(1, 0, FN_AND, 14, 2, 7, 32'h28);
        itype_op(1, FN_ADD, 15, 0, 12'h023, 32'h23);   // Shift 3 with bit 5 set
        rtype_op(1, 1, FN_SR, 17, 2, 15, 32'hffffffff);
        rtype_op(1, 0, FN_SR, 18, 2, 15, 32'h1fffffff);
        itype_op(1, FN_SLT, 19, 2, 12'hfff, 1);
        itype_op(1, FN_SLTU, 20, 3, 12'hfff, 1);
        itype_op(1, FN_XOR, 22, 1, 12'hfff, 32'hfffffffa);
        itype_op(1, FN_OR, 23, 3, 12'h100, 32'h103);
        itype_op(1, FN_AND, 24, 2, 12'h0ff, 32'hf8);
        itype_op(1, FN_SLL, 25, 1, 12'h004, 32'h50);
        itype_op(1, FN_SR, 26, 4, 12'h01f, 1);
        itype_op(1, FN_SR, 27, 4, 12'h404, 32'hf8000000);  // SRAI
        itype_op(2, FN_ADD, 1, 0, 12'd100, 100);
        itype_op(2, FN_ADD, 1, 1, 12'd1, 101);       // Distance one
        itype_op(2, FN_ADD, 2, 0, 12'd7, 7);
        rtype_op(2, 0, FN_ADD, 3, 1, 2, 108);        // Distances two and one
        itype_op(2, FN_ADD, 4, 0, 12'd9, 9);
        itype_op(2, FN_ADD, 5, 0, 12'd10, 10);
        rtype_op(2, 0, FN_ADD, 6, 3, 4, 117);        // Distance three
        itype_op(2, FN_ADD, 7, 0, 12'h033, 32'h33);
        bubble_slot(2);
        rtype_op(2, 1, FN_ADD, 8, 7, 5, 32'h29);
        itype_op(3, FN_ADD, 0, 0, 12'd55, 55);
        rtype_op(3, 0, FN_ADD, 12, 0, 0, 0);
        itype_op(3, FN_ADD, 0, 3, 12'd0, 108);
        bubble_slot(3);
        rtype_op(3, 0, FN_ADD, 13, 0, 3, 108);
        dropped(4, enc(7'h00, 5'd2, 5'd1, 3'd0, 5'd8, 7'h63));       // BEQ
        dropped(4, enc(7'h00, 5'd0, 5'd1, 3'd2, 5'd5, 7'h03));       // LW x5
        dropped(4, enc(7'h00, 5'd2, 5'd1, 3'd2, 5'd4, 7'h23));       // SW
        dropped(4, enc(7'h00, 5'd16, 5'd0, 3'd0, 5'd6, 7'h6f));      // JAL x6
        dropped(4, enc(7'h00, 5'd0, 5'd0, 3'd1, 5'd7, 7'h17));       // AUIPC x7
        dropped(4, enc(7'h20, 5'd1, 5'd1, FN_SLL, 5'd7, OPC_IMM));   // Bad SLLI funct7
        rtype_op(4, 0, FN_ADD, 15, 5, 0, 10);
        itype_op(4, FN_ADD, 16, 6, 12'd0, 117);
        itype_op(4, FN_ADD, 17, 7, 12'd0, 32'h33);
        itype_op(4, FN_ADD, 18, 8, 12'd0, 32'h29);   // Rd field of BEQ
        itype_op(4, FN_ADD, 19, 4, 12'd0, 9);        // Rd field of SW
    endtask

    task automatic check_data(string name, rv_pkg::xlen_t got, rv_pkg::xlen_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            test_errs[cur_test]++;
            n_errors++;
        end
    endtask

    task automatic check_rd(string name, rv_pkg::reg_addr_t got, rv_pkg::reg_addr_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            test_errs[cur_test]++;
            n_errors++;
        end
    endtask

    task automatic check_valid(string name, logic got, logic exp);
        n_checks++;
        if (got !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            test_errs[cur_test]++;
            n_errors++;
        end
    endtask

    task automatic report_test(int t);
        if (test_errs[t] == 0) n_pass++;
        $display("Test %0d (%s): %s, %0d errors", t, names[t],
                 (test_errs[t] == 0) ? "ok" : "FAILED", test_errs[t]);
    endtask

    // Result of the entry strobed two edges ago is on the outputs now
    task automatic retire();
        entry_t e;
        if (pend_q.size() < 2) return;
        e = pend_q.pop_front();
        if (e.test != cur_test) begin
            report_test(cur_test);
            cur_test = e.test;
        end
        check_valid("wb_valid", wb_valid, e.vld && e.legal);
        if (e.vld && e.legal) begin
            check_rd("wb_rd", wb_rd, e.rd);
            check_data("wb_data", wb_data, e.data);
        end
    endtask

    task automatic issue(entry_t e);
        retire();
        instr_valid = e.vld;
        instr       = e.instr;
        if (e.vld && e.legal && (e.rd != 0)) shadow[e.rd] = e.data;
        pend_q.push_back(e);
    endtask

    task automatic random_entry(output entry_t e);
        logic [31:0]       r;
        logic [2:0]        f3;
        logic              alt;
        logic [11:0]       imm;
        rv_pkg::reg_addr_t rd;
        rv_pkg::reg_addr_t rs1;
        rv_pkg::reg_addr_t rs2;
        rv_pkg::xlen_t     b;
        rnd = xorshift(rnd);
        r   = rnd;
        f3  = r[2:0];
        rd  = r[7:3];
        rs1 = r[12:8];
        rs2 = r[17:13];
        alt = r[18] && ((f3 == FN_SR) || (r[31] && (f3 == FN_ADD)));  // SUB only as R-type
        imm = ((f3 == FN_SLL) || (f3 == FN_SR)) ? {alt ? 7'h20 : 7'h00, r[23:19]} : r[30:19];
        if (r[31]) begin
            e.instr = enc(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OPC_OP);
            b = shadow[rs2];
        end else begin
            e.instr = enc(imm[11:5], imm[4:0], rs1, f3, rd, OPC_IMM);
            b = {{20{imm[11]}}, imm};
        end
        e.test  = 5;
        e.vld   = 1'b1;
        e.legal = 1'b1;
        e.rd    = rd;
        e.data  = alu_ref(f3, alt, shadow[rs1], b);
    endtask

    initial begin
        entry_t e;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        build_table();
        built = 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_valid("wb_valid", wb_valid, 1'b0);
        end
        rst = 1'b0;
        for (int i = 0; i < stim_q.size(); i++) begin
            @(negedge clk);
            issue(stim_q[i]);
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            random_entry(e);
            @(negedge clk);
            issue(e);
        end
        e = '{5, 1'b0, 32'd0, 1'b0, 5'd0, 32'd0};
        repeat (2) begin
            @(negedge clk);
            issue(e);  // Flush the last two results
        end
        report_test(cur_test);
        $display("%0d of 6 tests clean, %0d checks, %0d errors", n_pass, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait (built);
        #((stim_q.size() + N_RANDOM + 20) * CLK_PERIOD);
        $display("Watchdog expired before all results were checked");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* rv_core.f */
logic/rv_pkg.sv
logic/stage_if.sv
logic/rv_regfile.sv
logic/rv_decode.sv
logic/rv_id_ex.sv
logic/rv_execute.sv
logic/rv_core.sv
testbench/rv_core_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module rv_core_tb --Mdir obj_dir -o rv_core_sim -f rv_core.f
	@out="$$(./obj_dir/rv_core_sim)"; echo "$$out"; \
		echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
